// File: Bender.yml
package:
  name: bt_bridge

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/bt_bridge_pkg.sv
      - hdl/byte_fifo.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/rx_dispatch.sv
      - hdl/stream_scheduler.sv
      - hdl/link_sequencer.sv
      - hdl/bt_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_bt_bridge.sv

// File: hdl/bt_bridge_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth bridge configuration
// Stream count, FIFO depths, counter widths and command codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BT_BRIDGE_CFG_SVH
`define BT_BRIDGE_CFG_SVH

`define BT_N_STREAMS    4
`define BT_STREAM_DEPTH 16
`define BT_AT_DEPTH     32
`define BT_RSP_DEPTH    32
`define BT_BAUD_W       10

// Reply terminator from the module
`define BT_NEWLINE      8'h0A
// Upper nibble of select, low nibble is the enable mask
`define BT_CMD_SELECT   4'hA
`define BT_CMD_STOP     8'hB0

`endif

// File: hdl/bt_bridge_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth bridge types
// Byte, mask and counter types, UART settings, sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bt_bridge_cfg.svh"

package bt_bridge_pkg;

	typedef logic [7:0]                 byte_t;
	typedef logic [`BT_N_STREAMS-1:0]   stream_mask_t;
	typedef logic [1:0]                 stream_id_t;
	typedef logic [`BT_BAUD_W-1:0]      baud_count_t;

	// Runtime UART timing, shared by both UARTs and the sequencer
	typedef struct packed {
		baud_count_t cycles_per_bit;
		baud_count_t gap_cycles;
	} uart_cfg_t;

	typedef enum logic [3:0] {
		st_idle,
		st_load_cmd,
		st_rest_cmd,
		st_release,
		st_load_tx,
		st_send,
		st_rest_tx,
		st_wait_reply,
		st_wait_read,
		st_read_rsp,
		st_rest_rsp
	} seq_state_e;

endpackage

// File: hdl/bt_bridge_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth bridge top level
// Host AT path, sensor stream FIFOs and the UART link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module bt_bridge_top (
	input  logic                        clock,
	input  logic                        reset,
	input  bt_bridge_pkg::uart_cfg_t    cfg,
	input  logic                        want_at,
	input  logic                        at_req,
	input  bt_bridge_pkg::byte_t        at_byte,
	input  logic                        at_last,
	output logic                        at_ack,
	input  logic                        rsp_req,
	output bt_bridge_pkg::byte_t        rsp_byte,
	output logic                        rsp_last,
	output logic                        rsp_ack,
	input  bt_bridge_pkg::stream_mask_t stream_wr,
	input  bt_bridge_pkg::byte_t        stream_byte,
	output bt_bridge_pkg::stream_mask_t stream_full,
	input  logic                        rxd,
	output logic                        txd,
	output bt_bridge_pkg::seq_state_e   link_state
);

	bt_bridge_pkg::byte_t [`BT_N_STREAMS-1:0] stream_data;
	bt_bridge_pkg::stream_mask_t stream_empty;
	bt_bridge_pkg::stream_mask_t stream_rd;
	bt_bridge_pkg::stream_mask_t stream_mask;
	bt_bridge_pkg::stream_id_t   next_id;
	bt_bridge_pkg::byte_t        cmd_byte;
	bt_bridge_pkg::byte_t        rsp_data;
	bt_bridge_pkg::byte_t        tx_data;
	bt_bridge_pkg::byte_t        rx_byte;
	logic cmd_wr, cmd_rd, cmd_full, cmd_empty;
	logic rsp_wr, rsp_rd, rsp_empty, reply_done;
	logic stream_on, any_ready, take;
	logic tx_start, tx_done, rx_valid;

	for (genvar i = 0; i < `BT_N_STREAMS; i++)
	begin : g_stream
		// Only the stream the scheduler picked is popped
		assign stream_rd[i] = take & (next_id == bt_bridge_pkg::stream_id_t'(i));

		byte_fifo #(.DEPTH(`BT_STREAM_DEPTH)) u_fifo (
			.clock(clock), .reset(reset),
			.wr(stream_wr[i]), .wr_data(stream_byte),
			.rd(stream_rd[i]), .rd_data(stream_data[i]),
			.full(stream_full[i]), .empty(stream_empty[i])
		);
	end

	byte_fifo #(.DEPTH(`BT_AT_DEPTH)) u_cmd_fifo (
		.clock(clock), .reset(reset),
		.wr(cmd_wr), .wr_data(at_byte),
		.rd(cmd_rd), .rd_data(cmd_byte),
		.full(cmd_full), .empty(cmd_empty)
	);

	byte_fifo #(.DEPTH(`BT_RSP_DEPTH)) u_rsp_fifo (
		.clock(clock), .reset(reset),
		.wr(rsp_wr), .wr_data(rx_byte),
		.rd(rsp_rd), .rd_data(rsp_data),
		.full(), .empty(rsp_empty)
	);

	uart_tx u_uart_tx (
		.clock(clock), .reset(reset), .cfg(cfg),
		.start(tx_start), .data(tx_data), .txd(txd), .done(tx_done)
	);

	uart_rx u_uart_rx (
		.clock(clock), .reset(reset), .cfg(cfg),
		.rxd(rxd), .valid(rx_valid), .data(rx_byte)
	);

	rx_dispatch u_rx_dispatch (
		.clock(clock), .reset(reset), .want_at(want_at),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.rsp_wr(rsp_wr), .reply_done(reply_done),
		.stream_mask(stream_mask), .stream_on(stream_on)
	);

	stream_scheduler u_scheduler (
		.clock(clock), .reset(reset),
		.mask(stream_mask), .empty(stream_empty), .take(take),
		.next_id(next_id), .any_ready(any_ready)
	);

	link_sequencer u_sequencer (
		.clock(clock), .reset(reset), .cfg(cfg), .want_at(want_at),
		.at_req(at_req), .at_last(at_last), .at_ack(at_ack),
		.cmd_wr(cmd_wr), .cmd_full(cmd_full), .cmd_empty(cmd_empty),
		.cmd_byte(cmd_byte), .cmd_rd(cmd_rd),
		.stream_on(stream_on), .any_ready(any_ready), .next_id(next_id),
		.stream_bytes(stream_data), .take(take),
		.tx_start(tx_start), .tx_data(tx_data), .tx_done(tx_done),
		.reply_done(reply_done), .rsp_empty(rsp_empty), .rsp_data(rsp_data),
		.rsp_rd(rsp_rd), .rsp_req(rsp_req), .rsp_ack(rsp_ack),
		.rsp_byte(rsp_byte), .rsp_last(rsp_last), .state(link_state)
	);

endmodule

// File: hdl/byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte FIFO
// Circular buffer with first-word fall-through reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module byte_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 wr,
	input  bt_bridge_pkg::byte_t wr_data,
	input  logic                 rd,
	output bt_bridge_pkg::byte_t rd_data,
	output logic                 full,
	output logic                 empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	bt_bridge_pkg::byte_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// Writes while full and reads while empty are dropped
	assign do_wr   = wr & ~full;
	assign do_rd   = rd & ~empty;
	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// File: hdl/link_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link sequencer
// Command load, transmit with gap, reply wait and read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module link_sequencer (
	input  logic                                         clock,
	input  logic                                         reset,
	input  bt_bridge_pkg::uart_cfg_t                     cfg,
	input  logic                                         want_at,
	input  logic                                         at_req,
	input  logic                                         at_last,
	output logic                                         at_ack,
	output logic                                         cmd_wr,
	input  logic                                         cmd_full,
	input  logic                                         cmd_empty,
	input  bt_bridge_pkg::byte_t                         cmd_byte,
	output logic                                         cmd_rd,
	input  logic                                         stream_on,
	input  logic                                         any_ready,
	input  bt_bridge_pkg::stream_id_t                    next_id,
	input  bt_bridge_pkg::byte_t [`BT_N_STREAMS-1:0]     stream_bytes,
	output logic                                         take,
	output logic                                         tx_start,
	output bt_bridge_pkg::byte_t                         tx_data,
	input  logic                                         tx_done,
	input  logic                                         reply_done,
	input  logic                                         rsp_empty,
	input  bt_bridge_pkg::byte_t                         rsp_data,
	output logic                                         rsp_rd,
	input  logic                                         rsp_req,
	output logic                                         rsp_ack,
	output bt_bridge_pkg::byte_t                         rsp_byte,
	output logic                                         rsp_last,
	output bt_bridge_pkg::seq_state_e                    state
);

	bt_bridge_pkg::seq_state_e  next_state;
	bt_bridge_pkg::baud_count_t gap_cnt;
	logic                       last_seen;
	logic                       reply_seen;
	logic                       work;

	// Something left to send in the current mode
	assign work = want_at ? ~cmd_empty : (stream_on & any_ready);

	assign at_ack   = (state == bt_bridge_pkg::st_rest_cmd);
	assign cmd_wr   = (state == bt_bridge_pkg::st_load_cmd) & ~cmd_full;
	assign cmd_rd   = (state == bt_bridge_pkg::st_release) & want_at & work;
	assign take     = (state == bt_bridge_pkg::st_release) & ~want_at & work;
	assign tx_start = (state == bt_bridge_pkg::st_load_tx);
	assign rsp_rd   = (state == bt_bridge_pkg::st_read_rsp);
	assign rsp_ack  = (state == bt_bridge_pkg::st_rest_rsp);

	always_comb
	begin
		next_state = state;
		case (state)
			bt_bridge_pkg::st_idle:
			begin
				if (want_at && at_req)
					next_state = bt_bridge_pkg::st_load_cmd;
				else if (!want_at && work)
					next_state = bt_bridge_pkg::st_release;
			end
			// Held here while the command FIFO is full
			bt_bridge_pkg::st_load_cmd:
				if (!cmd_full)
					next_state = bt_bridge_pkg::st_rest_cmd;
			bt_bridge_pkg::st_rest_cmd:
				if (!at_req)
					next_state = last_seen ? bt_bridge_pkg::st_release : bt_bridge_pkg::st_idle;
			bt_bridge_pkg::st_release:
				next_state = work ? bt_bridge_pkg::st_load_tx : bt_bridge_pkg::st_idle;
			bt_bridge_pkg::st_load_tx:
				next_state = bt_bridge_pkg::st_send;
			bt_bridge_pkg::st_send:
				if (tx_done)
					next_state = bt_bridge_pkg::st_rest_tx;
			bt_bridge_pkg::st_rest_tx:
			begin
				if (gap_cnt <= 1)
				begin
					if (work)
						next_state = bt_bridge_pkg::st_release;
					else
						next_state = want_at ? bt_bridge_pkg::st_wait_reply : bt_bridge_pkg::st_idle;
				end
			end
			bt_bridge_pkg::st_wait_reply:
				if (reply_done || reply_seen)
					next_state = bt_bridge_pkg::st_wait_read;
			bt_bridge_pkg::st_wait_read:
				if (rsp_req && !rsp_empty)
					next_state = bt_bridge_pkg::st_read_rsp;
			bt_bridge_pkg::st_read_rsp:
				next_state = bt_bridge_pkg::st_rest_rsp;
			bt_bridge_pkg::st_rest_rsp:
				if (!rsp_req)
					next_state = rsp_last ? bt_bridge_pkg::st_idle : bt_bridge_pkg::st_wait_read;
			default:
				next_state = bt_bridge_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state      <= bt_bridge_pkg::st_idle;
			gap_cnt    <= '0;
			last_seen  <= 1'b0;
			reply_seen <= 1'b0;
			rsp_last   <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == bt_bridge_pkg::st_load_cmd)
				last_seen <= at_last;
			// Gap count is loaded as the frame ends and runs down in rest_tx
			if (state == bt_bridge_pkg::st_send)
				gap_cnt <= cfg.gap_cycles;
			else if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			// A newline may arrive before the last gap has run out
			if (state == bt_bridge_pkg::st_wait_reply)
				reply_seen <= 1'b0;
			else if (reply_done)
				reply_seen <= 1'b1;
			if (state == bt_bridge_pkg::st_read_rsp)
				rsp_last <= (rsp_data == `BT_NEWLINE);
		end
	end

	// Byte chosen at release, handed to the UART in load_tx
	always_ff @(posedge clock)
	begin
		if (state == bt_bridge_pkg::st_release)
			tx_data <= want_at ? cmd_byte : stream_bytes[next_id];
		if (state == bt_bridge_pkg::st_read_rsp)
			rsp_byte <= rsp_data;
	end

endmodule

// File: hdl/rx_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive dispatcher
// AT replies go to the reply FIFO, stream commands set the mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module rx_dispatch (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        want_at,
	input  logic                        rx_valid,
	input  bt_bridge_pkg::byte_t        rx_byte,
	output logic                        rsp_wr,
	output logic                        reply_done,
	output bt_bridge_pkg::stream_mask_t stream_mask,
	output logic                        stream_on
);

	logic app_cmd;

	// Every byte is reply data in AT mode
	assign rsp_wr     = want_at & rx_valid;
	assign reply_done = rsp_wr & (rx_byte == `BT_NEWLINE);
	assign app_cmd    = ~want_at & rx_valid;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			stream_mask <= '0;
			stream_on   <= 1'b0;
		end
		else if (app_cmd)
		begin
			if (rx_byte[7:4] == `BT_CMD_SELECT)
			begin
				stream_mask <= rx_byte[`BT_N_STREAMS-1:0];
				stream_on   <= 1'b1;
			end
			else if (rx_byte == `BT_CMD_STOP)
				stream_on <= 1'b0;
		end
	end

endmodule

// File: hdl/stream_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream scheduler
// Round-robin pick of the next enabled, non-empty stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module stream_scheduler (
	input  logic                        clock,
	input  logic                        reset,
	input  bt_bridge_pkg::stream_mask_t mask,
	input  bt_bridge_pkg::stream_mask_t empty,
	input  logic                        take,
	output bt_bridge_pkg::stream_id_t   next_id,
	output logic                        any_ready
);

	bt_bridge_pkg::stream_id_t   last_id;
	bt_bridge_pkg::stream_mask_t ready;

	assign ready     = mask & ~empty;
	assign any_ready = |ready;

	// Search starts just after the last served stream
	always_comb
	begin : pick
		int  idx;
		logic found;
		found   = 1'b0;
		next_id = last_id;
		for (int i = 1; i <= `BT_N_STREAMS; i++)
		begin
			idx = (int'(last_id) + i) % `BT_N_STREAMS;
			if (!found && ready[idx])
			begin
				found   = 1'b1;
				next_id = bt_bridge_pkg::stream_id_t'(idx);
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			last_id <= bt_bridge_pkg::stream_id_t'(`BT_N_STREAMS - 1);
		else if (take)
			last_id <= next_id;
	end

endmodule

// File: hdl/uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver
// 8N1 with start bit check and mid-bit sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_rx (
	input  logic                     clock,
	input  logic                     reset,
	input  bt_bridge_pkg::uart_cfg_t cfg,
	input  logic                     rxd,
	output logic                     valid,
	output bt_bridge_pkg::byte_t     data
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

	rx_state_e                  state;
	logic [1:0]                 sync;
	logic                       rxd_s;
	logic [2:0]                 bit_idx;
	bt_bridge_pkg::baud_count_t period_cnt;
	bt_bridge_pkg::byte_t       shreg;
	logic                       bit_end;

	assign rxd_s   = sync[1];
	assign data    = shreg;
	assign bit_end = (period_cnt == cfg.cycles_per_bit - 1'b1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sync       <= 2'b11;
			state      <= rx_idle;
			valid      <= 1'b0;
			bit_idx    <= '0;
			period_cnt <= '0;
		end
		else
		begin
			sync       <= {sync[0], rxd};
			valid      <= 1'b0;
			period_cnt <= period_cnt + 1'b1;
			case (state)
				rx_idle:
				begin
					period_cnt <= '0;
					if (!rxd_s)
						state <= rx_start;
				end
				// Half a bit in, the start bit must still be low
				rx_start:
				begin
					if (period_cnt == (cfg.cycles_per_bit >> 1) - 1'b1)
					begin
						period_cnt <= '0;
						bit_idx    <= '0;
						state      <= rxd_s ? rx_idle : rx_data;
					end
				end
				rx_data:
				begin
					if (bit_end)
					begin
						period_cnt <= '0;
						bit_idx    <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
				end
				default:
				begin
					// Low stop bit means a bad frame, so nothing is reported
					if (bit_end)
					begin
						valid <= rxd_s;
						state <= rx_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == rx_data && bit_end)
			shreg <= {rxd_s, shreg[7:1]};
	end

endmodule

// File: hdl/uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter
// 8N1 frames with a runtime bit period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx (
	input  logic                     clock,
	input  logic                     reset,
	input  bt_bridge_pkg::uart_cfg_t cfg,
	input  logic                     start,
	input  bt_bridge_pkg::byte_t     data,
	output logic                     txd,
	output logic                     done
);

	logic                       busy;
	logic [3:0]                 bit_idx;
	bt_bridge_pkg::baud_count_t period_cnt;
	// Stop bit, data LSB first, start bit
	logic [9:0]                 frame;

	assign txd = busy ? frame[0] : 1'b1;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy       <= 1'b0;
			done       <= 1'b0;
			bit_idx    <= '0;
			period_cnt <= '0;
			frame      <= '1;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (start)
				begin
					busy       <= 1'b1;
					bit_idx    <= '0;
					period_cnt <= '0;
					frame      <= {1'b1, data, 1'b0};
				end
			end
			else if (period_cnt == cfg.cycles_per_bit - 1'b1)
			begin
				period_cnt <= '0;
				frame      <= {1'b1, frame[9:1]};
				if (bit_idx == 4'd9)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				period_cnt <= period_cnt + 1'b1;
		end
	end

endmodule

// File: sim/tb_bt_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth bridge testbench
// UART line models, round-robin reference and txd byte checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "bt_bridge_cfg.svh"

module tb_bt_bridge;

	localparam int BIT_CYCLES = 8;
	localparam int W_AT_ACK = 0;
	localparam int W_RSP_ACK = 1;
	localparam int W_IDLE = 2;
	localparam int W_WAIT_REPLY = 3;
	localparam int W_RSP_DATA = 4;

	logic                        clock;
	logic                        reset;
	bt_bridge_pkg::uart_cfg_t    cfg;
	logic                        want_at;
	logic                        at_req;
	bt_bridge_pkg::byte_t        at_byte;
	logic                        at_last;
	logic                        at_ack;
	logic                        rsp_req;
	bt_bridge_pkg::byte_t        rsp_byte;
	logic                        rsp_last;
	logic                        rsp_ack;
	bt_bridge_pkg::stream_mask_t stream_wr;
	bt_bridge_pkg::byte_t        stream_byte;
	bt_bridge_pkg::stream_mask_t stream_full;
	logic                        rxd;
	logic                        txd;
	bt_bridge_pkg::seq_state_e   link_state;

	// Decoded txd bytes, expected bytes and the per-stream contents
	bt_bridge_pkg::byte_t got_q [$];
	bt_bridge_pkg::byte_t exp_q [$];
	bt_bridge_pkg::byte_t model_q [`BT_N_STREAMS][$];
	int rr_last = `BT_N_STREAMS - 1;
	int exp_total = 0;
	int compared = 0;
	int frames_started = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start = 0;

	bt_bridge_top u_dut (
		.clock(clock), .reset(reset), .cfg(cfg), .want_at(want_at),
		.at_req(at_req), .at_byte(at_byte), .at_last(at_last), .at_ack(at_ack),
		.rsp_req(rsp_req), .rsp_byte(rsp_byte), .rsp_last(rsp_last), .rsp_ack(rsp_ack),
		.stream_wr(stream_wr), .stream_byte(stream_byte), .stream_full(stream_full),
		.rxd(rxd), .txd(txd), .link_state(link_state)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// First stream after last, in cyclic order, that is ready
	function automatic int pick_next(input bt_bridge_pkg::stream_mask_t ready, input int last);
		int idx;
		pick_next = -1;
		for (int i = 1; i <= `BT_N_STREAMS; i++)
		begin
			idx = (last + i) % `BT_N_STREAMS;
			if (pick_next < 0 && ready[idx])
				pick_next = idx;
		end
	endfunction

	function automatic bt_bridge_pkg::stream_mask_t ready_streams(
		input bt_bridge_pkg::stream_mask_t mask);
		ready_streams = '0;
		for (int s = 0; s < `BT_N_STREAMS; s++)
			ready_streams[s] = mask[s] && (model_q[s].size() != 0);
	endfunction

	// Drains the enabled model streams into the expected txd sequence
	function automatic void build_expected(input bt_bridge_pkg::stream_mask_t mask);
		bt_bridge_pkg::stream_mask_t ready;
		int id;
		ready = ready_streams(mask);
		while (ready != '0)
		begin
			id = pick_next(ready, rr_last);
			exp_q.push_back(model_q[id].pop_front());
			exp_total++;
			rr_last = id;
			ready = ready_streams(mask);
		end
	endfunction

	function automatic logic probe(input int what);
		case (what)
			W_AT_ACK:     probe = at_ack;
			W_RSP_ACK:    probe = rsp_ack;
			W_IDLE:       probe = (link_state == bt_bridge_pkg::st_idle);
			W_WAIT_REPLY: probe = (link_state == bt_bridge_pkg::st_wait_reply);
			default:      probe = ~u_dut.rsp_empty;
		endcase
	endfunction

	task automatic abort_run(input string what);
		$display("Timeout at %0t: %s did not happen", $time, what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic wait_for(input int what, input logic level, input int limit, input string name);
		int n;
		n = 0;
		@(negedge clock);
		while (probe(what) !== level && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (probe(what) !== level)
			abort_run(name);
	endtask

	task automatic wait_for_bytes(input int target, input int limit, input string name);
		int n;
		n = 0;
		@(negedge clock);
		while (compared < target && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (compared < target)
			abort_run(name);
	endtask

	task automatic check_true(input logic ok, input string msg);
		checks++;
		assert (ok)
		else
		begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d %-18s %s, %0d errors", tests, name,
			(errors == test_start) ? "passed" : "failed", errors - test_start);
		test_start = errors;
	endtask

	// Drives an 8N1 frame on rxd with the LSB first
	task automatic send_rx_byte(input bt_bridge_pkg::byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clock);
			rxd <= frame[i];
			repeat (BIT_CYCLES - 1) @(posedge clock);
		end
	endtask

	task automatic load_cmd_byte(input bt_bridge_pkg::byte_t b, input logic last);
		@(posedge clock);
		at_req  <= 1'b1;
		at_byte <= b;
		at_last <= last;
		wait_for(W_AT_ACK, 1'b1, 200, "at_ack rising");
		@(posedge clock);
		at_req  <= 1'b0;
		at_last <= 1'b0;
		wait_for(W_AT_ACK, 1'b0, 200, "at_ack falling");
	endtask

	task automatic read_reply_byte(output bt_bridge_pkg::byte_t b, output logic last);
		@(posedge clock);
		rsp_req <= 1'b1;
		wait_for(W_RSP_ACK, 1'b1, 2000, "rsp_ack rising");
		b    = rsp_byte;
		last = rsp_last;
		@(posedge clock);
		rsp_req <= 1'b0;
		wait_for(W_RSP_ACK, 1'b0, 200, "rsp_ack falling");
	endtask

	// Sensor write that the model mirrors only while it has room
	task automatic write_stream(input int s, input bt_bridge_pkg::byte_t b);
		@(posedge clock);
		stream_wr   <= bt_bridge_pkg::stream_mask_t'(1 << s);
		stream_byte <= b;
		@(posedge clock);
		stream_wr   <= '0;
		if (model_q[s].size() < `BT_STREAM_DEPTH)
			model_q[s].push_back(b);
		@(negedge clock);
	endtask

	// Decodes txd by sampling each bit in its middle
	initial
	begin : decode_txd
		bt_bridge_pkg::byte_t b;
		forever
		begin
			@(negedge clock);
			if (txd === 1'b0)
			begin
				frames_started++;
				repeat (BIT_CYCLES / 2 - 1) @(negedge clock);
				assert (txd === 1'b0)
				else
				begin
					$display("Start bit on txd ended early at %0t", $time);
					errors++;
				end
				for (int i = 0; i < 8; i++)
				begin
					repeat (BIT_CYCLES) @(negedge clock);
					b[i] = txd;
				end
				repeat (BIT_CYCLES) @(negedge clock);
				assert (txd === 1'b1)
				else
				begin
					$display("Stop bit on txd was low at %0t", $time);
					errors++;
				end
				got_q.push_back(b);
			end
		end
	end

	// Compares every decoded byte with the next expected one
	initial
	begin : compare_txd
		bt_bridge_pkg::byte_t got;
		bt_bridge_pkg::byte_t want;
		forever
		begin
			@(posedge clock);
			while (got_q.size() != 0)
			begin
				got = got_q.pop_front();
				checks++;
				assert (exp_q.size() != 0)
				else
				begin
					$display("Unexpected byte %h on txd at %0t, none was due", got, $time);
					errors++;
				end
				if (exp_q.size() != 0)
				begin
					want = exp_q.pop_front();
					assert (got === want)
					else
					begin
						$display("CHECK FAILED at %0t: txd byte %h, expected %h", $time, got, want);
						errors++;
					end
				end
				compared++;
			end
		end
	end

	initial
	begin : run_tests
		bt_bridge_pkg::byte_t        b;
		bt_bridge_pkg::byte_t        reply [3];
		bt_bridge_pkg::stream_mask_t full_before;
		logic                        last;
		int                          count;
		int                          starts;
		void'($urandom(32'h5862));
		reset = 1'b1;
		cfg.cycles_per_bit = 10'd8;
		cfg.gap_cycles = 10'd12;
		want_at = 1'b1;
		at_req = 1'b0;
		at_byte = '0;
		at_last = 1'b0;
		rsp_req = 1'b0;
		stream_wr = '0;
		stream_byte = '0;
		rxd = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		check_true(txd === 1'b1, "txd not high after reset");
		check_true(at_ack === 1'b0 && rsp_ack === 1'b0, "handshake ack high after reset");
		check_true(rsp_last === 1'b0, "rsp_last high after reset");
		check_true(link_state == bt_bridge_pkg::st_idle, "link_state not idle after reset");
		end_test("reset_values");

		for (int i = 0; i < 5; i++)
		begin
			b = bt_bridge_pkg::byte_t'($urandom);
			exp_q.push_back(b);
			exp_total++;
			load_cmd_byte(b, i == 4);
		end
		wait_for_bytes(exp_total, 1500, "AT command bytes on txd");
		wait_for(W_WAIT_REPLY, 1'b1, 300, "wait_reply state");
		check_true(frames_started == exp_total, "frame count differs after AT command");
		end_test("at_transmit");

		reply[0] = 8'h4F;
		reply[1] = 8'h4B;
		reply[2] = `BT_NEWLINE;
		for (int i = 0; i < 3; i++)
			send_rx_byte(reply[i]);
		for (int i = 0; i < 3; i++)
		begin
			read_reply_byte(b, last);
			check_true(b === reply[i], $sformatf("reply byte %0d is %h", i, b));
			check_true(last === (i == 2), $sformatf("rsp_last is %b on reply byte %0d", last, i));
		end
		wait_for(W_IDLE, 1'b1, 50, "idle after reply read");
		end_test("at_reply");

		// In AT mode a select byte is only reply data
		send_rx_byte({`BT_CMD_SELECT, 4'b0101});
		wait_for(W_RSP_DATA, 1'b1, 200, "reply FIFO write");
		check_true(u_dut.stream_on === 1'b0, "select command turned streaming on in AT mode");
		check_true(u_dut.stream_mask === '0, "select command loaded a mask in AT mode");
		@(posedge clock);
		want_at <= 1'b0;
		end_test("at_mode_select");

		// Streams 1 and 3 start full so that a pop from them drops stream_full
		for (int s = 0; s < `BT_N_STREAMS; s++)
		begin
			count = (s % 2 == 1) ? `BT_STREAM_DEPTH : 4 + $urandom % 5;
			for (int k = 0; k < count; k++)
				write_stream(s, bt_bridge_pkg::byte_t'($urandom));
		end
		full_before = stream_full;
		build_expected(4'b0101);
		send_rx_byte({`BT_CMD_SELECT, 4'b0101});
		wait_for_bytes(exp_total, 4000, "streams 0 and 2 on txd");
		wait_for(W_IDLE, 1'b1, 300, "idle after streams 0 and 2");
		check_true(frames_started == exp_total, "extra frames from disabled streams");
		check_true(stream_full[1] === full_before[1], "stream_full[1] changed");
		check_true(stream_full[3] === full_before[3], "stream_full[3] changed");
		check_true(!u_dut.stream_empty[1] && !u_dut.stream_empty[3], "streams 1 and 3 drained");
		end_test("stream_round_robin");

		build_expected(4'b1010);
		count = compared;
		send_rx_byte({`BT_CMD_SELECT, 4'b1010});
		wait_for_bytes(count + 2, 1000, "first stream bytes before stop");
		send_rx_byte(`BT_CMD_STOP);
		starts = frames_started;
		wait_for(W_IDLE, 1'b1, 300, "idle after stop");
		check_true(frames_started <= starts + 1, "more than one frame after stop");
		check_true(!u_dut.stream_empty[1] && !u_dut.stream_empty[3],
			"stream bytes lost at the stop");
		send_rx_byte({`BT_CMD_SELECT, 4'b1010});
		wait_for_bytes(exp_total, 4000, "remaining bytes of streams 1 and 3");
		wait_for(W_IDLE, 1'b1, 300, "idle after resume");
		check_true(frames_started == exp_total, "frame count differs after resume");
		end_test("stop_resume");

		// Stream 0 is disabled while it fills past its depth
		for (int k = 0; k < `BT_STREAM_DEPTH + 4; k++)
		begin
			write_stream(0, bt_bridge_pkg::byte_t'($urandom));
			check_true(stream_full[0] === (model_q[0].size() >= `BT_STREAM_DEPTH),
				$sformatf("stream_full[0] is %b after %0d writes", stream_full[0], k + 1));
		end
		build_expected(4'b0001);
		send_rx_byte({`BT_CMD_SELECT, 4'b0001});
		wait_for_bytes(exp_total, 4000, "stream 0 bytes on txd");
		wait_for(W_IDLE, 1'b1, 300, "idle after stream 0");
		check_true(frames_started == exp_total, "bytes written while full were sent");
		end_test("back_pressure");

		check_true(exp_q.size() == 0, "expected bytes never appeared on txd");
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
hdl/bt_bridge_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/rx_dispatch.sv
hdl/stream_scheduler.sv
hdl/link_sequencer.sv
hdl/bt_bridge_top.sv
sim/tb_bt_bridge.sv
